/* always_valid_cyclic_bram.f */
+incdir+hw
hw/cyclic_bram_pkg.sv
hw/bram_port_if.sv
hw/sdp_bram.sv
hw/valid_delay.sv
hw/latency_ring.sv
hw/always_valid_cyclic_bram.sv
tb/tb_cyclic_bram.sv

/* Makefile */
TOP = tb_cyclic_bram
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f always_valid_cyclic_bram.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "test did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_cyclic_bram.sv */
//----------------------------------------------------------------------
// testbench for the always-valid cyclic read buffer
// each table row resets the DUT, fills the RAM with LFSR bytes and
// checks the wide read stream under back-pressure and clken gaps
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cyclic_bram_defines.svh"

module tb_cyclic_bram;

  localparam int NUM_ROWS = 6;

  logic                     clk;
  logic                     clken;
  logic                     rst;
  logic                     s_valid_ready;
  cyclic_bram_pkg::w_word_t s_data;
  logic                     m_ready;
  logic                     w_full;
  cyclic_bram_pkg::r_addr_t r_addr_max;
  cyclic_bram_pkg::r_addr_t r_addr_min;
  cyclic_bram_pkg::w_addr_t w_addr_max;
  cyclic_bram_pkg::r_word_t m_data;
  logic                     m_valid;

  // test table
  string row_name  [NUM_ROWS];
  int    row_w_max [NUM_ROWS];
  int    row_r_min [NUM_ROWS];
  int    row_r_max [NUM_ROWS];
  int    row_reads [NUM_ROWS];
  int    row_dens  [NUM_ROWS];  // LFSR bits ANDed into m_ready
  bit    row_gap   [NUM_ROWS];  // periodic clken drops

  logic [31:0]              lfsr = 32'h42ced211;
  cyclic_bram_pkg::w_word_t model [`CB_W_DEPTH];  // bytes written to the RAM
  cyclic_bram_pkg::r_word_t expected [$];
  string                    cur_name;
  int                       value_errors = 0;
  int                       other_errors = 0;
  int                       cycles = 0;
  int                       cycle_limit = 0;

  always_valid_cyclic_bram always_valid_cyclic_bram_inst (
    .clk           (clk),
    .clken         (clken),
    .rst           (rst),
    .s_valid_ready (s_valid_ready),
    .s_data        (s_data),
    .m_ready       (m_ready),
    .w_full        (w_full),
    .r_addr_max    (r_addr_max),
    .r_addr_min    (r_addr_min),
    .w_addr_max    (w_addr_max),
    .m_data        (m_data),
    .m_valid       (m_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      other_errors = other_errors + 1;
      $display("timeout after %0d cycles, the read stream never completed", cycles);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
    return {s[30:0], fb};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  function automatic cyclic_bram_pkg::w_word_t take_byte();
    cyclic_bram_pkg::w_word_t b;
    b = '0;
    for (int i = 0; i < `CB_W_WIDTH; i++) begin
      b = {b[`CB_W_WIDTH-2:0], take_bit()};
    end
    return b;
  endfunction

  function automatic logic draw_ready(input int dens);
    logic rdy;
    rdy = 1'b1;
    for (int i = 0; i < dens; i++) begin
      rdy = rdy & take_bit();
    end
    return rdy;
  endfunction

  task automatic add_row(input int r, input string name, input int w_max, input int r_min,
                         input int r_max, input int reads, input int dens, input bit gap);
    row_name[r]  = name;
    row_w_max[r] = w_max;
    row_r_min[r] = r_min;
    row_r_max[r] = r_max;
    row_reads[r] = reads;
    row_dens[r]  = dens;
    row_gap[r]   = gap;
  endtask

  task automatic load_table();
    //          name                  w_max r_min r_max reads dens gap
    add_row(0, "full_min0_no_stall",  15,   0,    7,    40,   0,   0);
    add_row(1, "wrap_min2",           15,   2,    7,    48,   1,   0);
    add_row(2, "heavy_backpressure",  15,   1,    7,    60,   2,   0);
    add_row(3, "clken_gaps",          15,   3,    6,    50,   1,   1);
    add_row(4, "partial_fill",        9,    1,    4,    40,   1,   0);
    add_row(5, "partial_fill_gaps",   11,   0,    5,    36,   2,   1);
  endtask

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    value_errors++;
    $display("FAIL %s: %s expected %h actual %h", cur_name, what, exp_v, act_v);
  endtask

  task automatic report_other(input string msg);
    other_errors++;
    $display("error in %s: %s", cur_name, msg);
  endtask

  task automatic apply_reset(input int r);
    @(negedge clk);
    rst           = 1'b1;
    clken         = 1'b1;
    s_valid_ready = 1'b0;
    s_data        = '0;
    m_ready       = 1'b0;
    w_addr_max    = cyclic_bram_pkg::w_addr_t'(row_w_max[r]);
    r_addr_min    = cyclic_bram_pkg::r_addr_t'(row_r_min[r]);
    r_addr_max    = cyclic_bram_pkg::r_addr_t'(row_r_max[r]);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (m_valid !== 1'b0) begin
      report_value("m_valid after reset", 32'd0, m_valid);
    end
  endtask

  // one write per cycle and w_full flags only the last one
  task automatic fill_ram(input int r);
    for (int i = 0; i <= row_w_max[r]; i++) begin
      if (m_valid !== 1'b0) begin
        report_value("m_valid during fill", 32'd0, m_valid);
      end
      if (w_full !== (i == row_w_max[r])) begin
        report_value($sformatf("w_full before write %0d", i), (i == row_w_max[r]), w_full);
      end
      model[i]      = take_byte();
      s_valid_ready = 1'b1;
      s_data        = model[i];
      @(negedge clk);
    end
    s_valid_ready = 1'b0;
    s_data        = '0;
  endtask

  // first pass covers words 0..r_max, later passes r_min..r_max
  task automatic build_expected(input int r);
    int a;
    int pass_len;
    expected.delete();
    pass_len = row_r_max[r] - row_r_min[r] + 1;
    for (int k = 0; k < row_reads[r]; k++) begin
      if (k <= row_r_max[r]) begin
        a = k;
      end else begin
        a = row_r_min[r] + (k - row_r_max[r] - 1) % pass_len;
      end
      expected.push_back({model[2*a+1], model[2*a]});  // lower write address in low bits
    end
  endtask

  task automatic stream_check(input int r);
    int                       idx;
    int                       rd_cycle;
    bit                       seen_valid;
    bit                       was_held;
    cyclic_bram_pkg::r_word_t last_data;
    idx        = 0;
    rd_cycle   = 0;
    seen_valid = 1'b0;
    was_held   = 1'b0;
    last_data  = '0;
    while (idx < row_reads[r]) begin
      if (w_full !== 1'b0) begin
        report_value("w_full after fill", 32'd0, w_full);
      end
      if (m_valid === 1'b1) begin
        seen_valid = 1'b1;
        if (m_data !== expected[idx]) begin
          report_value($sformatf("read word %0d", idx), expected[idx], m_data);
        end
      end else if (seen_valid) begin
        report_other("m_valid dropped after the stream had started");
      end
      if (was_held && m_data !== last_data) begin
        report_value("m_data while stalled", last_data, m_data);
      end
      m_ready   = draw_ready(row_dens[r]);
      clken     = !(row_gap[r] && (rd_cycle % 17) >= 12);  // 5-cycle clken gaps
      was_held  = m_valid && !(m_ready && clken);
      last_data = m_data;
      if (m_valid && m_ready && clken) begin
        idx++;  // the next rising edge pops one word
      end
      rd_cycle++;
      @(negedge clk);
    end
    m_ready = 1'b0;
    clken   = 1'b1;
  endtask

  initial begin
    clk           = 1'b0;
    clken         = 1'b1;
    rst           = 1'b1;
    s_valid_ready = 1'b0;
    s_data        = '0;
    m_ready       = 1'b0;
    r_addr_max    = '0;
    r_addr_min    = '0;
    w_addr_max    = '0;
    load_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += (18 + row_w_max[r] + 1 + row_reads[r]) * 4;
    end
    cycle_limit += 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name = row_name[r];
      apply_reset(r);
      fill_ram(r);
      build_expected(r);
      stream_check(r);
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/always_valid_cyclic_bram.sv */
//----------------------------------------------------------------------
// always-valid cyclic read buffer: fill the RAM through the narrow port,
// then stream wide words 0..r_addr_max, r_addr_min..r_addr_max, ...
// m_valid stays high once filled; clken freezes everything
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module always_valid_cyclic_bram (
  input  wire logic                      clk,
  input  wire logic                      clken,
  input  wire logic                      rst,
  input  wire logic                      s_valid_ready,  // one write per high cycle
  input  wire cyclic_bram_pkg::w_word_t  s_data,
  input  wire logic                      m_ready,
  output logic                           w_full,
  input  wire cyclic_bram_pkg::r_addr_t  r_addr_max,
  input  wire cyclic_bram_pkg::r_addr_t  r_addr_min,
  input  wire cyclic_bram_pkg::w_addr_t  w_addr_max,
  output cyclic_bram_pkg::r_word_t       m_data,
  output logic                           m_valid
);

  cyclic_bram_pkg::fill_state_t state, state_next;

  cyclic_bram_pkg::w_addr_t addr_w_prev, addr_w;
  cyclic_bram_pkg::r_addr_t addr_r;

  logic wr_fire;
  logic rd_en;
  logic rd_valid;
  logic ring_full;

  bram_port_if bram ();

  assign wr_fire = s_valid_ready && (state == cyclic_bram_pkg::WRITE_S);

  always_comb begin
    state_next = state;
    case (state)
      cyclic_bram_pkg::WRITE_S:  if (wr_fire && addr_w == w_addr_max) begin
        state_next = cyclic_bram_pkg::FILL_1_S;
      end
      cyclic_bram_pkg::FILL_1_S: if (rd_valid) begin
        state_next = cyclic_bram_pkg::FILL_2_S;
      end
      cyclic_bram_pkg::FILL_2_S: if (ring_full) begin
        state_next = cyclic_bram_pkg::READ_S;
      end
      default: state_next = state;
    endcase
  end

  // once m_valid is up, every pop issues one replacement read,
  // so ring plus in-flight reads always hold LATENCY+1 words
  always_comb begin
    case (state)
      cyclic_bram_pkg::FILL_1_S: begin
        rd_en   = 1'b1;
        m_valid = 1'b0;
      end
      cyclic_bram_pkg::FILL_2_S, cyclic_bram_pkg::READ_S: begin
        rd_en   = m_ready;
        m_valid = 1'b1;
      end
      default: begin
        rd_en   = 1'b0;
        m_valid = 1'b0;
      end
    endcase
  end

  // write address wraps at w_addr_max, starts one before 0
  assign addr_w = (addr_w_prev == w_addr_max) ? '0 : addr_w_prev + 1'b1;
  assign w_full = (state == cyclic_bram_pkg::WRITE_S) && (addr_w == w_addr_max);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= cyclic_bram_pkg::WRITE_S;
      addr_w_prev <= '1;
      addr_r      <= '0;
    end else if (clken) begin
      state <= state_next;
      if (wr_fire) begin
        addr_w_prev <= addr_w;
      end
      if (rd_en) begin
        addr_r <= (addr_r == r_addr_max) ? r_addr_min : addr_r + 1'b1;  // skip config words
      end
    end
  end

  assign bram.we    = wr_fire;
  assign bram.waddr = addr_w;
  assign bram.wdata = s_data;
  assign bram.re    = rd_en;
  assign bram.raddr = addr_r;

  sdp_bram sdp_bram_inst (
    .clk   (clk),
    .clken (clken),
    .port  (bram.mem)
  );

  valid_delay valid_delay_inst (
    .clk   (clk),
    .rst   (rst),
    .clken (clken),
    .din   (rd_en),
    .dout  (rd_valid)
  );

  latency_ring latency_ring_inst (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .rd_valid (rd_valid),
    .rdata    (bram.rdata),
    .m_ready  (m_ready),
    .m_valid  (m_valid),
    .m_data   (m_data),
    .full     (ring_full)
  );

endmodule

`default_nettype wire

/* hw/latency_ring.sv */
//----------------------------------------------------------------------
// ring of CB_BUF_DEPTH wide words in front of the RAM read port
// returning reads are written at w_ptr, the consumer sees slot r_ptr
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cyclic_bram_defines.svh"

module latency_ring (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      clken,
  input  wire logic                      rd_valid,
  input  wire cyclic_bram_pkg::r_word_t  rdata,
  input  wire logic                      m_ready,
  input  wire logic                      m_valid,
  output cyclic_bram_pkg::r_word_t       m_data,
  output logic                           full
);

  localparam int PTR_W = $clog2(`CB_BUF_DEPTH);
  localparam int CNT_W = $clog2(`CB_LATENCY + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`CB_BUF_DEPTH - 1);

  cyclic_bram_pkg::r_word_t slots [`CB_BUF_DEPTH];

  logic [PTR_W-1:0] w_ptr, r_ptr;
  logic [CNT_W-1:0] hold_cnt;  // blocks writes right after reset
  logic             wr_en;
  logic             pop;

  assign wr_en = rd_valid && (hold_cnt == '0);
  assign pop   = m_valid && m_ready;

  // slot at the end of the fill is being written this cycle
  assign full = wr_en && (w_ptr == LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      hold_cnt <= CNT_W'(`CB_LATENCY);
    end else if (clken && hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else if (clken) begin
      if (wr_en) begin
        w_ptr <= (w_ptr == LAST) ? '0 : w_ptr + 1'b1;
      end
      if (pop) begin
        r_ptr <= (r_ptr == LAST) ? '0 : r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken && wr_en) begin
      slots[w_ptr] <= rdata;
    end
  end

  assign m_data = slots[r_ptr];  // head word, straight from the slot

endmodule

`default_nettype wire

/* hw/valid_delay.sv */
//----------------------------------------------------------------------
// delays the RAM read enable by the RAM latency
// dout is high in the cycles where rdata carries a requested word
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cyclic_bram_defines.svh"

module valid_delay (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic clken,
  input  wire logic din,
  output logic      dout
);

  logic [`CB_LATENCY-1:0] taps;  // taps[0] is the newest read

  always_ff @(posedge clk) begin
    if (rst) begin
      taps <= '0;
    end else if (clken) begin
      taps[0] <= din;
      for (int i = 1; i < `CB_LATENCY; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign dout = taps[`CB_LATENCY-1];

endmodule

`default_nettype wire

/* hw/sdp_bram.sv */
//----------------------------------------------------------------------
// behavioral simple dual-port RAM, narrow write and wide read
// a wide read returns consecutive narrow words, lowest address in the
// low bits, after a fixed pipeline of CB_LATENCY stages
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

`include "cyclic_bram_defines.svh"

module sdp_bram (
  input  wire logic  clk,
  input  wire logic  clken,
  bram_port_if.mem   port
);

  localparam int RATIO = `CB_R_WIDTH / `CB_W_WIDTH;  // narrow words per wide word

  cyclic_bram_pkg::w_word_t mem [`CB_W_DEPTH];
  cyclic_bram_pkg::r_word_t rd_word;               // assembled wide word
  cyclic_bram_pkg::r_word_t pipe [`CB_LATENCY];    // output register chain

  always_ff @(posedge clk) begin
    if (clken && port.we) begin
      mem[port.waddr] <= port.wdata;
    end
  end

  // word k holds narrow words RATIO*k .. RATIO*k+RATIO-1
  always_comb begin
    for (int j = 0; j < RATIO; j++) begin
      rd_word[j*`CB_W_WIDTH +: `CB_W_WIDTH] = mem[RATIO*int'(port.raddr) + j];
    end
  end

  // stage 0 latches only on a read, the rest shift every enabled cycle
  // so that several reads can be in flight
  always_ff @(posedge clk) begin
    if (clken) begin
      if (port.re) begin
        pipe[0] <= rd_word;
      end
      for (int i = 1; i < `CB_LATENCY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign port.rdata = pipe[`CB_LATENCY-1];

endmodule

`default_nettype wire

/* hw/bram_port_if.sv */
//----------------------------------------------------------------------
// write and read ports of the simple dual-port RAM
// the controller drives addresses and enables, the RAM returns rdata
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

interface bram_port_if;

  logic                       we;
  cyclic_bram_pkg::w_addr_t   waddr;
  cyclic_bram_pkg::w_word_t   wdata;
  logic                       re;
  cyclic_bram_pkg::r_addr_t   raddr;
  cyclic_bram_pkg::r_word_t   rdata;  // valid LATENCY cycles after re

  modport ctrl (output we, waddr, wdata, re, raddr, input rdata);
  modport mem  (input we, waddr, wdata, re, raddr, output rdata);

endinterface

`default_nettype wire

/* hw/cyclic_bram_pkg.sv */
//----------------------------------------------------------------------
// types shared by the cyclic read buffer
// address and word types follow the sizes in the defines header
//----------------------------------------------------------------------

`default_nettype none

`include "cyclic_bram_defines.svh"

package cyclic_bram_pkg;

  typedef logic [`CB_W_AWIDTH-1:0] w_addr_t;  // one narrow word
  typedef logic [`CB_R_AWIDTH-1:0] r_addr_t;  // one wide word

  typedef logic [`CB_W_WIDTH-1:0] w_word_t;
  typedef logic [`CB_R_WIDTH-1:0] r_word_t;

  // fill first, prime the ring, then stream forever
  typedef enum logic [1:0] {
    WRITE_S  = 2'd0,
    FILL_1_S = 2'd1,  // reads issued, waiting for the first return
    FILL_2_S = 2'd2,  // ring catching the remaining returns
    READ_S   = 2'd3
  } fill_state_t;

endpackage

`default_nettype wire

/* hw/cyclic_bram_defines.svh */
//----------------------------------------------------------------------
// sizes of the cyclic read buffer: word widths, RAM depths, read latency
// include this wherever a CB_ macro is needed
//----------------------------------------------------------------------

`ifndef CYCLIC_BRAM_DEFINES_SVH
`define CYCLIC_BRAM_DEFINES_SVH

`define CB_W_WIDTH   8   // narrow write word
`define CB_R_WIDTH   16  // wide read word
`define CB_W_DEPTH   16  // words on the write side
`define CB_LATENCY   3   // RAM read latency in cycles

`define CB_R_DEPTH   ((`CB_W_DEPTH * `CB_W_WIDTH) / `CB_R_WIDTH)
`define CB_W_AWIDTH  $clog2(`CB_W_DEPTH)
`define CB_R_AWIDTH  $clog2(`CB_R_DEPTH)
`define CB_BUF_DEPTH (`CB_LATENCY + 1)  // enough slots to hide the latency

`endif
